/* sample_pkg.sv */
package sample_pkg;

  // samples per block, fixed at build time
  localparam int n_samples = 8;
  localparam int idx_w = 3;  // enough bits to address every sample in a block

  // one signed audio-rate sample as it travels on the stream
  typedef logic signed [15:0] sample_t;

  // a whole block moves between stages as one unpacked array
  typedef sample_t block_t [n_samples];

  // position of a sample inside its block
  typedef logic [idx_w-1:0] idx_t;

  // largest and smallest value a sample can hold
  localparam sample_t sample_max = 16'sh7fff;
  localparam sample_t sample_min = 16'sh8000;

  // index of the last sample in a block
  localparam idx_t last_idx = idx_t'(n_samples - 1);

endpackage

/* scale_cfg_pkg.sv */
package scale_cfg_pkg;

  typedef logic [7:0] gain_t;  // unsigned gain applied to each sample
  typedef logic [3:0] shift_t;  // right shift applied after the multiply
  typedef logic [1:0] ctrl_t;  // mode bits of the control register
  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  // register map of the write port
  localparam cfg_addr_t addr_gain = 2'd0;
  localparam cfg_addr_t addr_shift = 2'd1;
  localparam cfg_addr_t addr_ctrl = 2'd2;

  // bit positions inside the control register
  localparam int ctrl_round_bit = 0;
  localparam int ctrl_sat_bit = 1;

  // values after reset give a unity path with no rounding and no clamping
  localparam gain_t gain_reset = 8'd1;
  localparam shift_t shift_reset = 4'd0;
  localparam ctrl_t ctrl_reset = 2'b00;

endpackage

/* scale_cfg_if.sv */
`timescale 1ns/100ps

interface scale_cfg_if
  import scale_cfg_pkg::*;
();

  gain_t gain;
  shift_t shift;
  logic round_en;  // add half an output step before the shift
  logic sat_en;  // clamp instead of wrapping

  // the register block owns the configuration
  modport cfg_src(output gain, output shift, output round_en, output sat_en);

  // the scaler only reads it
  modport cfg_dst(input gain, input shift, input round_en, input sat_en);

endinterface

/* deserializer.sv */
`timescale 1ns/100ps

module deserializer
  import sample_pkg::*;
(
  input logic clk,
  input logic reset,

  input logic in_valid,
  output logic in_ready,
  input sample_t in_sample,

  output logic blk_valid,
  input logic blk_ready,
  output block_t blk_data
);

  typedef enum logic {
    st_collect,
    st_full
  } state_t;

  state_t state;
  state_t state_next;
  idx_t count;
  logic in_fire;
  logic [n_samples-1:0] wr_sel;
  sample_t sample_q [n_samples];

  assign in_ready = (state == st_collect);
  assign blk_valid = (state == st_full);
  assign in_fire = in_valid && in_ready;

  // one-hot select of the register that takes the current sample
  assign wr_sel = in_fire ? (n_samples'(1) << count) : '0;

  always_comb begin
    state_next = state;
    case (state)
      st_collect: begin
        if (in_fire && count == last_idx) begin
          state_next = st_full;
        end
      end
      st_full: begin
        if (blk_ready) begin
          state_next = st_collect;  // block leaves on this edge
        end
      end
      default: state_next = st_collect;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_collect;
      count <= '0;
    end else begin
      state <= state_next;
      if (in_fire) begin
        count <= count + idx_t'(1);  // wraps back to 0 after the last sample
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < n_samples; i++) begin
      if (wr_sel[i]) begin
        sample_q[i] <= in_sample;
      end
    end
  end

  assign blk_data = sample_q;

endmodule

/* scale_cfg_regs.sv */
`timescale 1ns/100ps

module scale_cfg_regs
  import scale_cfg_pkg::*;
(
  input logic clk,
  input logic reset,

  input logic cfg_wr_en,
  input cfg_addr_t cfg_addr,
  input cfg_data_t cfg_data,

  scale_cfg_if.cfg_src cfg
);

  gain_t gain_q;
  shift_t shift_q;
  ctrl_t ctrl_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      gain_q <= gain_reset;
      shift_q <= shift_reset;
      ctrl_q <= ctrl_reset;
    end else if (cfg_wr_en) begin
      case (cfg_addr)
        addr_gain: begin
          gain_q <= cfg_data;
        end
        addr_shift: begin
          shift_q <= cfg_data[3:0];  // upper bits of the write are dropped
        end
        addr_ctrl: begin
          ctrl_q <= cfg_data[1:0];
        end
        default: begin
          // address 3 has no register behind it
        end
      endcase
    end
  end

  assign cfg.gain = gain_q;
  assign cfg.shift = shift_q;
  assign cfg.round_en = ctrl_q[ctrl_round_bit];
  assign cfg.sat_en = ctrl_q[ctrl_sat_bit];

endmodule

/* block_scaler.sv */
`timescale 1ns/100ps

module block_scaler
  import sample_pkg::*;
  import scale_cfg_pkg::*;
(
  input logic clk,
  input logic reset,

  scale_cfg_if.cfg_dst cfg,

  input logic blk_valid,
  output logic blk_ready,
  input block_t blk_data,

  output logic sc_valid,
  input logic sc_ready,
  output block_t sc_data
);

  logic valid_q;
  logic blk_fire;
  block_t scaled;
  block_t sc_data_q;

  // multiply, optional round, arithmetic shift, then clamp or wrap
  function automatic sample_t scale_sample(sample_t s, gain_t g, shift_t sh, logic rnd,
                                           logic sat);
    logic signed [24:0] prod;
    logic signed [24:0] shifted;
    prod = s * $signed({1'b0, g});  // 24 bits suffice, one spare bit covers the round add
    if (rnd && sh != 4'd0) begin
      prod = prod + (25'sd1 <<< (sh - 4'd1));
    end
    shifted = prod >>> sh;
    if (sat) begin
      if (shifted > 25'sd32767) begin
        return sample_max;
      end
      if (shifted < -25'sd32768) begin
        return sample_min;
      end
    end
    return sample_t'(shifted[15:0]);
  endfunction

  always_comb begin
    for (int i = 0; i < n_samples; i++) begin
      scaled[i] = scale_sample(blk_data[i], cfg.gain, cfg.shift, cfg.round_en, cfg.sat_en);
    end
  end

  // the output register frees up on the same edge it is read out
  assign blk_ready = !valid_q || sc_ready;
  assign blk_fire = blk_valid && blk_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (blk_fire) begin
      valid_q <= 1'b1;
    end else if (sc_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (blk_fire) begin
      sc_data_q <= scaled;  // configuration is sampled with the block
    end
  end

  assign sc_valid = valid_q;
  assign sc_data = sc_data_q;

endmodule

/* serializer.sv */
`timescale 1ns/100ps

module serializer
  import sample_pkg::*;
(
  input logic clk,
  input logic reset,

  input logic sc_valid,
  output logic sc_ready,
  input block_t sc_data,

  output logic out_valid,
  input logic out_ready,
  output sample_t out_sample
);

  typedef enum logic {
    st_empty,
    st_sending
  } state_t;

  state_t state;
  idx_t rd_idx;
  logic sc_fire;
  logic out_fire;
  block_t buf_q;

  assign sc_ready = (state == st_empty);
  assign out_valid = (state == st_sending);
  assign sc_fire = sc_valid && sc_ready;
  assign out_fire = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_empty;
      rd_idx <= '0;
    end else begin
      case (state)
        st_empty: begin
          if (sc_fire) begin
            state <= st_sending;
            rd_idx <= '0;
          end
        end
        st_sending: begin
          if (out_fire) begin
            rd_idx <= rd_idx + idx_t'(1);
            if (rd_idx == last_idx) begin
              state <= st_empty;  // last sample is gone, take the next block
            end
          end
        end
        default: state <= st_empty;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sc_fire) begin
      buf_q <= sc_data;
    end
  end

  assign out_sample = buf_q[rd_idx];

endmodule

/* sample_block_top.sv */
`timescale 1ns/100ps

module sample_block_top
  import sample_pkg::*;
  import scale_cfg_pkg::*;
(
  input logic clk,
  input logic reset,

  input logic cfg_wr_en,
  input cfg_addr_t cfg_addr,
  input cfg_data_t cfg_data,

  input logic in_valid,
  output logic in_ready,
  input sample_t in_sample,

  output logic out_valid,
  input logic out_ready,
  output sample_t out_sample
);

  logic blk_valid;
  logic blk_ready;
  block_t blk_data;

  logic sc_valid;
  logic sc_ready;
  block_t sc_data;

  scale_cfg_if cfg_bus ();

  deserializer u_deserializer (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_sample(in_sample),
    .blk_valid(blk_valid),
    .blk_ready(blk_ready),
    .blk_data(blk_data)
  );

  scale_cfg_regs u_cfg_regs (
    .clk(clk),
    .reset(reset),
    .cfg_wr_en(cfg_wr_en),
    .cfg_addr(cfg_addr),
    .cfg_data(cfg_data),
    .cfg(cfg_bus.cfg_src)
  );

  // one block in flight between the collector and the output stage
  block_scaler u_scaler (
    .clk(clk),
    .reset(reset),
    .cfg(cfg_bus.cfg_dst),
    .blk_valid(blk_valid),
    .blk_ready(blk_ready),
    .blk_data(blk_data),
    .sc_valid(sc_valid),
    .sc_ready(sc_ready),
    .sc_data(sc_data)
  );

  serializer u_serializer (
    .clk(clk),
    .reset(reset),
    .sc_valid(sc_valid),
    .sc_ready(sc_ready),
    .sc_data(sc_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_sample(out_sample)
  );

endmodule

/* tb_sample_block.sv */
`timescale 1ns/100ps

module tb_sample_block
  import sample_pkg::*;
  import scale_cfg_pkg::*;
();

  typedef enum logic [1:0] {
    stall_none,
    stall_in,
    stall_out,
    stall_both
  } stall_t;

  typedef struct packed {
    gain_t gain;
    shift_t shift;
    logic rnd;
    logic sat;
    logic [3:0] blocks;
    stall_t stall;
    logic replay;  // reuse the samples of the row before
    logic junk_write;  // also write to the unmapped address
  } test_row_t;

  localparam int n_tests = 11;
  localparam logic [31:0] lfsr_taps = 32'h80200003;

  logic clk;
  logic reset;
  logic cfg_wr_en;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_data;
  logic in_valid;
  logic in_ready;
  sample_t in_sample;
  logic out_valid;
  logic out_ready;
  sample_t out_sample;

  test_row_t rows [n_tests];
  string names [n_tests];
  logic [31:0] lfsr;
  logic [31:0] row_seed;
  int errors;
  int timeouts;

  sample_block_top dut (
    .clk(clk),
    .reset(reset),
    .cfg_wr_en(cfg_wr_en),
    .cfg_addr(cfg_addr),
    .cfg_data(cfg_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_sample(in_sample),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_sample(out_sample)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_lfsr(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ lfsr_taps;
    end
    return s >> 1;
  endfunction

  // one lfsr step for every bit handed out
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = next_lfsr(lfsr);
    end
    return bits;
  endfunction

  // model of the scaling rule in wide signed integer arithmetic
  function automatic sample_t expected_scaled(sample_t s, gain_t g, shift_t sh, logic rnd,
                                              logic sat);
    longint p;
    p = longint'(s) * longint'(g);
    if (rnd && sh != 4'd0) begin
      p = p + (longint'(1) << (int'(sh) - 1));  // half of one output step
    end
    p = p >>> sh;  // floor division by a power of two
    if (sat && p > 32767) begin
      return 16'sh7fff;
    end
    if (sat && p < -32768) begin
      return 16'sh8000;
    end
    return sample_t'(p[15:0]);
  endfunction

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
    @(negedge clk);
    cfg_wr_en = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    @(negedge clk);
    cfg_wr_en = 1'b0;
  endtask

  task automatic load_table();
    rows[0] = '{8'd1, 4'd0, 1'b0, 1'b0, 4'd2, stall_none, 1'b0, 1'b0};
    names[0] = "unity";
    rows[1] = '{8'd3, 4'd2, 1'b0, 1'b0, 4'd2, stall_none, 1'b0, 1'b0};
    names[1] = "truncate";
    rows[2] = '{8'd5, 4'd3, 1'b1, 1'b0, 4'd2, stall_none, 1'b0, 1'b0};
    names[2] = "round";
    rows[3] = '{8'd77, 4'd7, 1'b1, 1'b0, 4'd2, stall_none, 1'b0, 1'b0};
    names[3] = "round_wide_shift";
    rows[4] = '{8'd200, 4'd1, 1'b0, 1'b1, 4'd2, stall_none, 1'b0, 1'b0};
    names[4] = "saturate";
    rows[5] = '{8'd200, 4'd1, 1'b0, 1'b0, 4'd2, stall_none, 1'b1, 1'b0};
    names[5] = "wrap";
    rows[6] = '{8'd11, 4'd3, 1'b1, 1'b1, 4'd6, stall_both, 1'b0, 1'b0};
    names[6] = "stall_both";
    rows[7] = '{8'd2, 4'd1, 1'b0, 1'b0, 4'd4, stall_in, 1'b0, 1'b0};
    names[7] = "input_gaps";
    rows[8] = '{8'd9, 4'd2, 1'b1, 1'b0, 4'd4, stall_out, 1'b0, 1'b0};
    names[8] = "output_stalls";
    rows[9] = '{8'd6, 4'd2, 1'b0, 1'b1, 4'd2, stall_none, 1'b0, 1'b1};
    names[9] = "addr3_ignored";
    rows[10] = '{8'd1, 4'd0, 1'b0, 1'b0, 4'd2, stall_both, 1'b0, 1'b0};
    names[10] = "reconfig";
  endtask

  task automatic run_row(input int t);
    test_row_t row;
    sample_t stim [$];
    sample_t expect_q [$];
    sample_t exp_val;
    int total;
    int n_in;
    int n_out;
    int cycles;
    int limit;
    logic gaps;
    logic stalls;
    logic in_fire;
    logic out_fire;
    row = rows[t];
    total = int'(row.blocks) * n_samples;
    gaps = (row.stall == stall_in) || (row.stall == stall_both);
    stalls = (row.stall == stall_out) || (row.stall == stall_both);
    if (row.replay) begin
      lfsr = row_seed;
    end else begin
      row_seed = lfsr;
    end
    write_reg(addr_gain, row.gain);
    write_reg(addr_shift, cfg_data_t'(row.shift));
    write_reg(addr_ctrl, {6'd0, row.sat, row.rnd});
    if (row.junk_write) begin
      write_reg(2'd3, 8'hff);  // must not touch any register
    end
    for (int i = 0; i < total; i++) begin
      stim.push_back(sample_t'(take_bits(16)));
      expect_q.push_back(expected_scaled(stim[i], row.gain, row.shift, row.rnd, row.sat));
    end
    n_in = 0;
    n_out = 0;
    cycles = 0;
    in_fire = 1'b0;
    limit = total * 20 + 100;
    while (n_out < total && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (in_fire) begin
        n_in++;
        in_valid = 1'b0;
      end
      if (!in_valid && n_in < total) begin
        if (!gaps || take_bits(1) != 0) begin
          in_valid = 1'b1;
          in_sample = stim[n_in];
        end
      end
      out_ready = stalls ? (take_bits(1) != 0) : 1'b1;
      // ready and valid only change at the rising edge, so the transfer is known here
      in_fire = in_valid && in_ready;
      out_fire = out_valid && out_ready;
      if (out_fire) begin
        exp_val = expect_q.pop_front();
        check_sample($sformatf("%s sample %0d", names[t], n_out), exp_val, out_sample);
        n_out++;
      end
    end
    if (n_out < total) begin
      timeouts++;
      $display("timeout in %s: only %0d of %0d samples came out", names[t], n_out, total);
    end else begin
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (!(in_ready && !out_valid) && cycles < 20);
      check_flag($sformatf("%s in_ready idle", names[t]), 1'b1, in_ready);
      check_flag($sformatf("%s out_valid idle", names[t]), 1'b0, out_valid);
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cfg_wr_en = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    in_valid = 1'b0;
    in_sample = '0;
    out_ready = 1'b0;
    lfsr = 32'hd880af3b;
    row_seed = lfsr;
    errors = 0;
    timeouts = 0;
    load_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("reset in_ready", 1'b1, in_ready);
    check_flag("reset out_valid", 1'b0, out_valid);
    for (int t = 0; t < n_tests; t++) begin
      run_row(t);
      if (timeouts != 0) begin
        break;  // the pipeline is stuck, later rows would only time out too
      end
    end
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sample_block.f */
sample_pkg.sv
scale_cfg_pkg.sv
scale_cfg_if.sv
deserializer.sv
scale_cfg_regs.sv
block_scaler.sv
serializer.sv
sample_block_top.sv
tb_sample_block.sv
